/* heapMemory.f */
+incdir+source
source/heapPkg.sv
source/heapCommandIf.sv
source/commandIntake.sv
source/arrayAllocator.sv
source/arrayStore.sv
source/responseQueue.sv
source/heapMemory.sv
tb/heapMemory_properties.sv
tb/heapMemoryChecker.sv
tb/heapMemoryTb.sv

/* source/arrayAllocator.sv */
/*
  Array allocator
  Live flags, LIFO stack of freed arrays and a counter of fresh arrays
*/
`timescale 1ns/1ps
`include "heap_params.svh"

module arrayAllocator import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  heapCommandIf.observe command,
  input  logic          allocTake,       // Hand out allocArray
  input  logic          freeTake,        // Push command array on free stack
  output logic          arrayLive,       // Live flag of command array
  output arrayT         allocArray,      // Next array an Alloc gets
  output logic          allocAvailable   // Some array left to hand out
);

  localparam int CountBits = $clog2(`HEAP_ARRAYS + 1);
  localparam logic [CountBits-1:0] AllArrays = `HEAP_ARRAYS;

  logic [`HEAP_ARRAYS-1:0] live;        // One flag per array
  arrayT                   freeStack [`HEAP_ARRAYS];
  logic [CountBits-1:0]    stackTop;    // Entries on the free stack
  logic [CountBits-1:0]    fresh;       // Arrays never issued start here
  logic                    stackEmpty;

  assign stackEmpty     = stackTop == '0;
  assign arrayLive      = live[command.array];
  assign allocArray     = stackEmpty ? arrayT'(fresh)
                                     : freeStack[arrayT'(stackTop - 1'b1)];  // Last freed first
  assign allocAvailable = !(stackEmpty && fresh == AllArrays);

  // --------------------
  // Free stack storage
  always_ff @(posedge clock) begin
    if (freeTake) begin
      freeStack[arrayT'(stackTop)] <= command.array;  // Only live arrays get here
    end
  end

  // --------------------
  // Control state
  always_ff @(posedge clock) begin
    if (reset) begin
      live     <= '0;
      stackTop <= '0;
      fresh    <= '0;
    end else if (allocTake) begin
      live[allocArray] <= 1'b1;
      if (stackEmpty) begin
        fresh <= fresh + 1'b1;                        // Issue a new one
      end else begin
        stackTop <= stackTop - 1'b1;                  // Reuse a freed one
      end
    end else if (freeTake) begin
      live[command.array] <= 1'b0;
      stackTop            <= stackTop + 1'b1;
    end
  end

endmodule

/* source/arrayStore.sv */
/*
  Array store
  Element memory and sizes, executes each command and decides its error
*/
`timescale 1ns/1ps
`include "heap_params.svh"

module arrayStore import heapPkg::*; (
  input  logic       clock,
  input  logic       reset,
  heapCommandIf.sink command,
  input  logic       arrayLive,
  input  arrayT      allocArray,
  input  logic       allocAvailable,
  input  logic       spaceAvailable,  // Response FIFO has room
  output logic       allocTake,
  output logic       freeTake,
  output logic       resultValid,
  output dataT       resultData,
  output errorT      resultError
);

  dataT  elements [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];  // Fixed block per array
  sizeT  sizes    [`HEAP_ARRAYS];
  logic  fire;                                         // Command executes now
  sizeT  arraySize;                                    // Size of command array
  dataT  elementValue;                                 // Element at command index
  logic  inBounds;                                     // Index below size
  indexT lastIndex;                                    // Top element for Pop
  sizeT  lessCount;
  dataT  sum;
  logic  writeEnable;
  indexT writeIndex;
  dataT  writeValue;
  logic  sizeEnable;
  arrayT sizeArray;                                    // Alloc sets another array's size
  sizeT  sizeValue;

  assign command.ready = spaceAvailable;               // Stall while responses back up
  assign fire          = command.valid && command.ready;
  assign arraySize     = sizes[command.array];
  assign elementValue  = elements[command.array][command.index];
  assign inBounds      = sizeT'(command.index) < arraySize;
  assign lastIndex     = indexT'(arraySize - 1'b1);
  assign sum           = elementValue + command.data;  // Wraps at data width
  assign resultValid   = fire;
  assign allocTake     = fire && command.action == `HEAP_OP_ALLOC && resultError == `HEAP_ERR_NONE;
  assign freeTake      = fire && command.action == `HEAP_OP_FREE && resultError == `HEAP_ERR_NONE;

  always_comb begin                                    // CountLess over live elements
    lessCount = '0;
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      if (sizeT'(i) < arraySize && elements[command.array][i] < command.data) begin
        lessCount = lessCount + 1'b1;
      end
    end
  end

  // --------------------
  // Decode and error decisions
  always_comb begin
    resultError = `HEAP_ERR_NONE;
    resultData  = '0;
    writeEnable = 1'b0;
    writeIndex  = command.index;
    writeValue  = command.data;
    sizeEnable  = 1'b0;
    sizeArray   = command.array;
    sizeValue   = arraySize;
    if (command.action != `HEAP_OP_ALLOC && !arrayLive) begin
      resultError = `HEAP_ERR_NOT_ALLOCATED;           // Catches double free too
    end else begin
      case (command.action)
        `HEAP_OP_ALLOC: begin
          if (!allocAvailable) begin
            resultError = `HEAP_ERR_OUT_OF_MEMORY;
          end else begin
            sizeEnable = 1'b1;                         // New array starts empty
            sizeArray  = allocArray;
            sizeValue  = '0;
            resultData = dataT'(allocArray);
          end
        end
        `HEAP_OP_WRITE: begin
          writeEnable = 1'b1;
          sizeEnable  = !inBounds;                     // Extend past the end
          sizeValue   = sizeT'(command.index) + 1'b1;
          resultData  = command.data;
        end
        `HEAP_OP_READ: begin
          if (!inBounds) resultError = `HEAP_ERR_OUT_OF_BOUNDS;
          else resultData = elementValue;
        end
        `HEAP_OP_SIZE:       resultData = dataT'(arraySize);
        `HEAP_OP_COUNT_LESS: resultData = dataT'(lessCount);
        `HEAP_OP_PUSH: begin
          if (arraySize == sizeT'(`HEAP_ARRAY_LENGTH)) begin
            resultError = `HEAP_ERR_FULL;
          end else begin
            writeEnable = 1'b1;
            writeIndex  = indexT'(arraySize);          // Below length here
            sizeEnable  = 1'b1;
            sizeValue   = arraySize + 1'b1;
          end
        end
        `HEAP_OP_POP: begin
          if (arraySize == '0) begin
            resultError = `HEAP_ERR_EMPTY;
          end else begin
            sizeEnable = 1'b1;
            sizeValue  = arraySize - 1'b1;
            resultData = elements[command.array][lastIndex];
          end
        end
        `HEAP_OP_ADD: begin
          if (!inBounds) begin
            resultError = `HEAP_ERR_OUT_OF_BOUNDS;
          end else begin
            writeEnable = 1'b1;
            writeValue  = sum;
            resultData  = sum;
          end
        end
        default: resultData = '0;                      // Free, unknown opcodes
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) begin
        sizes[a] <= '0;
        for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) elements[a][i] <= '0;
      end
    end else if (fire) begin
      if (writeEnable) elements[command.array][writeIndex] <= writeValue;
      if (sizeEnable) sizes[sizeArray] <= sizeValue;
    end
  end

endmodule

/* source/commandIntake.sv */
/*
  Command intake
  FIFO for host commands, returns one credit per command that leaves
*/
`timescale 1ns/1ps
`include "heap_params.svh"

module commandIntake import heapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         commandValid,   // One cycle per command, host holds a credit
  input  actionT       commandAction,
  input  arrayT        commandArray,
  input  indexT        commandIndex,
  input  dataT         commandData,
  output logic         commandCredit,  // Pulse as a command leaves
  heapCommandIf.source command
);

  localparam int PtrBits = $clog2(`HEAP_CMD_DEPTH);

  actionT             actionFifo [`HEAP_CMD_DEPTH];  // Payload storage
  arrayT              arrayFifo  [`HEAP_CMD_DEPTH];
  indexT              indexFifo  [`HEAP_CMD_DEPTH];
  dataT               dataFifo   [`HEAP_CMD_DEPTH];
  logic [PtrBits-1:0] writePtr;
  logic [PtrBits-1:0] readPtr;
  logic [PtrBits:0]   count;                         // Entries held
  logic               take;                          // Head leaves this cycle

  assign take           = command.valid && command.ready;
  assign commandCredit  = take;                      // Credit goes back with the handshake
  assign command.valid  = count != '0;
  assign command.action = actionFifo[readPtr];       // Head on the channel
  assign command.array  = arrayFifo[readPtr];
  assign command.index  = indexFifo[readPtr];
  assign command.data   = dataFifo[readPtr];

  always_ff @(posedge clock) begin
    if (commandValid) begin                          // Host never overfills
      actionFifo[writePtr] <= commandAction;
      arrayFifo[writePtr]  <= commandArray;
      indexFifo[writePtr]  <= commandIndex;
      dataFifo[writePtr]   <= commandData;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
    end else begin
      if (commandValid) writePtr <= writePtr + 1'b1;  // Depth is a power of two
      if (take) readPtr <= readPtr + 1'b1;
      case ({commandValid, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                     // Both or neither
      endcase
    end
  end

endmodule

/* source/heapCommandIf.sv */
/*
  Heap command channel
  One command with valid/ready from the intake FIFO to the processing part
*/
`timescale 1ns/1ps

interface heapCommandIf import heapPkg::*; ();

  logic   valid;   // Head of intake FIFO present
  logic   ready;   // Processing part can take it
  actionT action;  // Opcode
  arrayT  array;
  indexT  index;
  dataT   data;

  modport source  (output valid, action, array, index, data, input ready);
  modport sink    (input valid, action, array, index, data, output ready);
  modport observe (input valid, ready, action, array, index, data);  // Allocator only looks

endinterface

/* source/heapMemory.sv */
/*
  Heap memory top level
  Credit-controlled command and response ports around the multi-array heap
*/
`timescale 1ns/1ps

module heapMemory import heapPkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   commandValid,
  input  actionT commandAction,
  input  arrayT  commandArray,
  input  indexT  commandIndex,
  input  dataT   commandData,
  output logic   commandCredit,
  input  logic   responseCredit,
  output logic   responseValid,
  output dataT   responseData,
  output errorT  responseError
);

  heapCommandIf command ();        // Intake to store and allocator

  logic  allocTake;
  logic  freeTake;
  logic  arrayLive;
  arrayT allocArray;
  logic  allocAvailable;
  logic  spaceAvailable;           // Back-pressure from response FIFO
  logic  resultValid;
  dataT  resultData;
  errorT resultError;

  // --------------------
  // Input side
  commandIntake i_commandIntake (
    .clock, .reset, .commandValid, .commandAction, .commandArray,
    .commandIndex, .commandData, .commandCredit,
    .command (command.source)
  );

  // --------------------
  // Processing part
  arrayAllocator i_arrayAllocator (
    .clock, .reset, .allocTake, .freeTake, .arrayLive, .allocArray, .allocAvailable,
    .command (command.observe)
  );

  arrayStore i_arrayStore (
    .clock, .reset, .arrayLive, .allocArray, .allocAvailable, .spaceAvailable,
    .allocTake, .freeTake, .resultValid, .resultData, .resultError,
    .command (command.sink)
  );

  // --------------------
  // Output side
  responseQueue i_responseQueue (
    .clock, .reset, .resultValid, .resultData, .resultError, .responseCredit,
    .spaceAvailable, .responseValid, .responseData, .responseError
  );

endmodule

/* source/heapPkg.sv */
/*
  Heap memory types
  Vector typedefs for the fields of commands, responses and array state
*/
`include "heap_params.svh"

package heapPkg;

  // --------------------
  // Command fields
  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayT;   // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;   // Element index
  typedef logic [3:0]                  actionT;  // Opcode

  // --------------------
  // Array state and results
  typedef logic [`HEAP_INDEX_BITS:0]   sizeT;    // Zero up to the full length
  typedef logic [`HEAP_DATA_BITS-1:0]  dataT;    // Element and response data
  typedef logic [2:0]                  errorT;   // Error code

endpackage

/* source/heap_params.svh */
/*
  Heap memory parameters
  Widths, depths, opcodes and error codes for the design and its testbench
*/
`ifndef HEAP_PARAMS_SVH
`define HEAP_PARAMS_SVH

// --------------------
// Sizes
`define HEAP_ARRAY_BITS         2     // Bits in an array number
`define HEAP_INDEX_BITS         3     // Bits in an element index
`define HEAP_DATA_BITS          16    // Element width
`define HEAP_ARRAYS             4     // Arrays in the heap
`define HEAP_ARRAY_LENGTH       8     // Max elements per array
`define HEAP_CMD_DEPTH          4     // Command FIFO depth, initial host credits
`define HEAP_RSP_DEPTH          4     // Response FIFO depth

// --------------------
// Opcodes
`define HEAP_OP_ALLOC           4'd1  // Take a freed or fresh array
`define HEAP_OP_FREE            4'd2
`define HEAP_OP_WRITE           4'd3  // Store, may extend the size
`define HEAP_OP_READ            4'd4
`define HEAP_OP_SIZE            4'd5
`define HEAP_OP_PUSH            4'd6
`define HEAP_OP_POP             4'd7
`define HEAP_OP_COUNT_LESS      4'd8  // Elements below size less than data
`define HEAP_OP_ADD             4'd9  // Returns the new value

// --------------------
// Error codes
`define HEAP_ERR_NONE           3'd0
`define HEAP_ERR_NOT_ALLOCATED  3'd1  // Array not live, also a double free
`define HEAP_ERR_OUT_OF_BOUNDS  3'd2
`define HEAP_ERR_FULL           3'd3
`define HEAP_ERR_EMPTY          3'd4
`define HEAP_ERR_OUT_OF_MEMORY  3'd5

`endif

/* source/responseQueue.sv */
/*
  Response queue
  Result FIFO that sends its head only while a response credit is held
*/
`timescale 1ns/1ps
`include "heap_params.svh"

module responseQueue import heapPkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  resultValid,      // Result from array store
  input  dataT  resultData,
  input  errorT resultError,
  input  logic  responseCredit,   // Host can take one more
  output logic  spaceAvailable,   // Fewer than depth entries held
  output logic  responseValid,
  output dataT  responseData,
  output errorT responseError
);

  localparam int PtrBits    = $clog2(`HEAP_RSP_DEPTH);
  localparam int CreditBits = $clog2(`HEAP_RSP_DEPTH + `HEAP_CMD_DEPTH + 1);
  localparam logic [PtrBits:0] Depth = `HEAP_RSP_DEPTH;

  dataT                  dataFifo  [`HEAP_RSP_DEPTH];
  errorT                 errorFifo [`HEAP_RSP_DEPTH];
  logic [PtrBits-1:0]    writePtr;
  logic [PtrBits-1:0]    readPtr;
  logic [PtrBits:0]      count;
  logic [CreditBits-1:0] credits;  // Unspent response credits

  assign spaceAvailable = count < Depth;
  assign responseValid  = count != '0 && credits != '0;  // Send spends a credit
  assign responseData   = dataFifo[readPtr];
  assign responseError  = errorFifo[readPtr];

  always_ff @(posedge clock) begin
    if (resultValid) begin                             // Only written with space
      dataFifo[writePtr]  <= resultData;
      errorFifo[writePtr] <= resultError;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
      credits  <= '0;
    end else begin
      if (resultValid) writePtr <= writePtr + 1'b1;
      if (responseValid) readPtr <= readPtr + 1'b1;
      case ({resultValid, responseValid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({responseCredit, responseValid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;                   // New credit covers the send
      endcase
    end
  end

endmodule

/* tb/heapMemoryChecker.sv */
/*
  Heap memory checker
  Reference model of arrays and allocator, queues expected results in command order
  and compares every response
*/
`timescale 1ns/1ps
`include "heap_params.svh"

module heapMemoryChecker import heapPkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   commandValid,
  input  actionT commandAction,
  input  arrayT  commandArray,
  input  indexT  commandIndex,
  input  dataT   commandData,
  input  logic   commandCredit,
  input  logic   responseValid,
  input  dataT   responseData,
  input  errorT  responseError,
  output int     errorCount,
  output int     checkCount,
  output int     creditCount,   // commandCredit pulses seen
  output int     pendingCount   // Responses still owed
);

  typedef struct packed {
    errorT error;
    dataT  data;
  } resultT;

  dataT   memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  int     sizes  [`HEAP_ARRAYS];
  bit     live   [`HEAP_ARRAYS];
  arrayT  freeList [$];   // Last freed at the back
  int     freshNext;      // Next never-issued array
  resultT expected [$];

  // --------------------
  // Reference model, one command at a time
  function automatic resultT referenceResult(input actionT action, input arrayT array,
                                             input indexT index, input dataT data);
    resultT result;
    int     count;
    result.error = `HEAP_ERR_NONE;
    result.data  = '0;
    count        = 0;
    if (action == `HEAP_OP_ALLOC) begin
      if (freeList.size() != 0) begin
        result.data = dataT'(freeList.pop_back());   // LIFO reuse
      end else if (freshNext < `HEAP_ARRAYS) begin
        result.data = dataT'(freshNext);
        freshNext++;
      end else begin
        result.error = `HEAP_ERR_OUT_OF_MEMORY;
      end
      if (result.error == `HEAP_ERR_NONE) begin
        live[result.data]  = 1'b1;
        sizes[result.data] = 0;                       // Elements kept, size cleared
      end
      return result;
    end
    if (!live[array]) begin
      result.error = `HEAP_ERR_NOT_ALLOCATED;         // Nothing changes
      return result;
    end
    case (action)
      `HEAP_OP_FREE: begin
        live[array] = 1'b0;
        freeList.push_back(array);
      end
      `HEAP_OP_WRITE: begin
        memory[array][index] = data;
        if (int'(index) >= sizes[array]) sizes[array] = int'(index) + 1;
        result.data = data;
      end
      `HEAP_OP_READ: begin
        if (int'(index) < sizes[array]) result.data = memory[array][index];
        else result.error = `HEAP_ERR_OUT_OF_BOUNDS;
      end
      `HEAP_OP_SIZE: result.data = dataT'(sizes[array]);
      `HEAP_OP_PUSH: begin
        if (sizes[array] == `HEAP_ARRAY_LENGTH) begin
          result.error = `HEAP_ERR_FULL;
        end else begin
          memory[array][sizes[array]] = data;
          sizes[array]++;
        end
      end
      `HEAP_OP_POP: begin
        if (sizes[array] == 0) begin
          result.error = `HEAP_ERR_EMPTY;
        end else begin
          sizes[array]--;
          result.data = memory[array][sizes[array]];  // Top element
        end
      end
      `HEAP_OP_COUNT_LESS: begin
        for (int i = 0; i < sizes[array]; i++) begin
          if (memory[array][i] < data) count++;
        end
        result.data = dataT'(count);
      end
      `HEAP_OP_ADD: begin
        if (int'(index) < sizes[array]) begin
          memory[array][index] = memory[array][index] + data;  // Wraps at 16 bits
          result.data          = memory[array][index];
        end else begin
          result.error = `HEAP_ERR_OUT_OF_BOUNDS;
        end
      end
      default: result.data = '0;
    endcase
    return result;
  endfunction

  // --------------------
  // Compare process
  always @(posedge clock) begin : compare
    resultT head;
    if (reset) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) begin
        sizes[a] = 0;
        live[a]  = 1'b0;
        for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) memory[a][i] = '0;
      end
      freeList.delete();
      expected.delete();
      freshNext   = 0;
      errorCount  = 0;
      checkCount  = 0;
      creditCount = 0;
    end else begin
      if (responseValid) begin
        if (expected.size() == 0) begin
          $display("Response arrived at %0t ns with no command outstanding", $time);
          errorCount++;
        end else begin
          head = expected.pop_front();
          checkCount++;
          if (responseData !== head.data) begin
            $display("FAIL responseData expected %h got %h", head.data, responseData);
            errorCount++;
          end
          if (responseError !== head.error) begin
            $display("FAIL responseError expected %h got %h", head.error, responseError);
            errorCount++;
          end
        end
      end
      if (commandValid) begin
        expected.push_back(referenceResult(commandAction, commandArray, commandIndex,
                                           commandData));
      end
      if (commandCredit) creditCount++;
    end
    pendingCount = expected.size();
  end

endmodule

/* tb/heapMemoryTb.sv */
/*
  Heap memory testbench
  Directed phases, then an LFSR mix with response credits withheld at random
*/
`timescale 1ns/1ps
`include "heap_params.svh"

module heapMemoryTb import heapPkg::*; ();

  localparam int DirectedCommands = 60;    // Bound on the directed phases
  localparam int RandomCommands   = 400;
  localparam int MaxHeldCredits   = `HEAP_RSP_DEPTH + `HEAP_CMD_DEPTH;
  localparam int TimeoutNs        = (DirectedCommands + RandomCommands) * 40 * 8;

  logic        clock;
  logic        reset;
  logic        commandValid;
  actionT      commandAction;
  arrayT       commandArray;
  indexT       commandIndex;
  dataT        commandData;
  logic        commandCredit;
  logic        responseCredit;
  logic        responseValid;
  dataT        responseData;
  errorT       responseError;
  int          hostCredits;       // Command credits the host holds
  int          heldCredits;       // Response credits granted, not yet spent
  int          sentCount;
  int          tbErrors;
  int          assertErrors;      // Failed credit-rule assertions
  logic        withholdCredits;   // Random credit grants when set
  logic [16:0] stimulusLfsr;
  logic [16:0] creditLfsr;
  int          errorCount;
  int          checkCount;
  int          creditCount;
  int          pendingCount;

  heapMemory i_heapMemory (.*);

  heapMemoryChecker i_heapMemoryChecker (.*);

  bind heapMemory heapMemoryProperties i_heapMemoryProperties (
    .clock(clock), .reset(reset), .commandValid(commandValid), .commandCredit(commandCredit),
    .responseCredit(responseCredit), .responseValid(responseValid)
  );

  assign assertErrors = i_heapMemory.i_heapMemoryProperties.failures;

  always #4 clock = ~clock;       // 8 ns period

  // --------------------
  // Random source
  function automatic logic [16:0] lfsrStep(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};  // x^17 + x^14 + 1
  endfunction

  function automatic logic [15:0] drawBits(input int count);
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      stimulusLfsr = lfsrStep(stimulusLfsr);      // One step per bit
      value        = {value[14:0], stimulusLfsr[0]};
    end
    return value;
  endfunction

  // --------------------
  // Credit bookkeeping
  always @(posedge clock) begin
    if (reset) begin
      hostCredits <= `HEAP_CMD_DEPTH;
      heldCredits <= 0;
    end else begin
      hostCredits <= hostCredits + int'(commandCredit) - int'(commandValid);
      heldCredits <= heldCredits + int'(responseCredit) - int'(responseValid);
    end
  end

  always @(posedge clock) begin
    #1;
    creditLfsr     = lfsrStep(creditLfsr);
    responseCredit = !reset && heldCredits < MaxHeldCredits
                     && (!withholdCredits || creditLfsr[0]);  // Stay within the counter
  end

  task automatic sendCommand(input actionT action, input arrayT array, input indexT index,
                             input dataT data);
    while (hostCredits == 0) begin
      @(posedge clock);
      #1;
    end
    commandValid  = 1'b1;
    commandAction = action;
    commandArray  = array;
    commandIndex  = index;
    commandData   = data;
    @(posedge clock);
    #1;
    commandValid = 1'b0;
    sentCount++;
  endtask

  // --------------------
  // Stimulus
  initial begin
    actionT action;
    clock           = 1'b0;
    reset           = 1'b1;
    commandValid    = 1'b0;
    commandAction   = '0;
    commandArray    = '0;
    commandIndex    = '0;
    commandData     = '0;
    responseCredit  = 1'b0;
    withholdCredits = 1'b0;
    stimulusLfsr    = 17'd71932;
    creditLfsr      = 17'd71932;
    sentCount       = 0;
    tbErrors        = 0;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;

    sendCommand(`HEAP_OP_READ, 2'd0, 3'd0, 16'h0000);       // Nothing live yet
    repeat (5) sendCommand(`HEAP_OP_ALLOC, 2'd0, 3'd0, 16'h0000);  // 0..3 then out of memory
    sendCommand(`HEAP_OP_FREE, 2'd2, 3'd0, 16'h0000);
    sendCommand(`HEAP_OP_FREE, 2'd1, 3'd0, 16'h0000);
    repeat (2) sendCommand(`HEAP_OP_ALLOC, 2'd0, 3'd0, 16'h0000);  // 1 then 2

    sendCommand(`HEAP_OP_WRITE, 2'd0, 3'd2, 16'h1234);
    sendCommand(`HEAP_OP_WRITE, 2'd0, 3'd5, 16'hbeef);      // Size grows to 6
    sendCommand(`HEAP_OP_READ, 2'd0, 3'd2, 16'h0000);
    sendCommand(`HEAP_OP_READ, 2'd0, 3'd5, 16'h0000);
    sendCommand(`HEAP_OP_SIZE, 2'd0, 3'd0, 16'h0000);
    sendCommand(`HEAP_OP_READ, 2'd0, 3'd6, 16'h0000);       // At the size
    sendCommand(`HEAP_OP_READ, 2'd0, 3'd7, 16'h0000);

    for (int i = 0; i < 9; i++) sendCommand(`HEAP_OP_PUSH, 2'd1, 3'd0, dataT'(16'h0100 + i));
    for (int i = 0; i < 9; i++) sendCommand(`HEAP_OP_POP, 2'd1, 3'd0, 16'h0000);

    sendCommand(`HEAP_OP_COUNT_LESS, 2'd0, 3'd0, 16'h2000);
    sendCommand(`HEAP_OP_COUNT_LESS, 2'd0, 3'd0, 16'hffff);
    sendCommand(`HEAP_OP_ADD, 2'd0, 3'd2, 16'hf000);        // Wraps around
    sendCommand(`HEAP_OP_READ, 2'd0, 3'd2, 16'h0000);
    sendCommand(`HEAP_OP_ADD, 2'd0, 3'd7, 16'h0001);

    sendCommand(`HEAP_OP_FREE, 2'd3, 3'd0, 16'h0000);
    for (int op = `HEAP_OP_FREE; op <= `HEAP_OP_ADD; op++) begin
      sendCommand(actionT'(op), 2'd3, 3'd1, 16'h0055);      // Dead array including a second free
    end
    sendCommand(`HEAP_OP_ALLOC, 2'd0, 3'd0, 16'h0000);
    sendCommand(`HEAP_OP_WRITE, 2'd3, 3'd7, 16'h0000);      // Opens all eight elements
    sendCommand(`HEAP_OP_COUNT_LESS, 2'd3, 3'd0, 16'h0001); // Eight zeros if dead ops left no data

    withholdCredits = 1'b1;
    repeat (RandomCommands) begin
      action = actionT'(drawBits(4) % 9 + 1);
      sendCommand(action, arrayT'(drawBits(2)), indexT'(drawBits(3)), drawBits(16));
    end
    withholdCredits = 1'b0;

    while (pendingCount != 0) begin                         // Drain responses
      @(posedge clock);
      #1;
    end
    repeat (10) @(posedge clock);
    #1;
    if (creditCount != sentCount) begin
      $display("FAIL commandCredit pulses expected %h got %h", sentCount, creditCount);
      tbErrors++;
    end
    $display("Checked %0d, checker errors %0d, testbench errors %0d, assertion errors %0d",
             checkCount, errorCount, tbErrors, assertErrors);
    if (errorCount + tbErrors + assertErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // --------------------
  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("Run did not finish within %0d ns, %0d responses still owed",
             TimeoutNs, pendingCount);
    $display("Checked %0d, checker errors %0d, testbench errors %0d, assertion errors %0d",
             checkCount, errorCount, tbErrors, assertErrors);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* tb/heapMemory_properties.sv */
/*
  Heap memory credit rules
  Concurrent assertions on both credit loops, bound into the top level
*/
`timescale 1ns/1ps

module heapMemoryProperties (
  input logic clock,
  input logic reset,
  input logic commandValid,
  input logic commandCredit,
  input logic responseCredit,
  input logic responseValid
);

  int granted;   // Response credits from the host
  int sent;      // Responses sent
  int accepted;  // Commands taken in
  int returned;  // Command credits handed back
  int failures;  // Failed assertions so far

  always_ff @(posedge clock) begin
    if (reset) begin
      granted  <= 0;
      sent     <= 0;
      accepted <= 0;
      returned <= 0;
    end else begin
      if (responseCredit) granted <= granted + 1;
      if (responseValid) sent <= sent + 1;
      if (commandValid) accepted <= accepted + 1;
      if (commandCredit) returned <= returned + 1;
    end
  end

  // --------------------
  // Credit rules
  sendNeedsCredit: assert property (@(posedge clock) disable iff (reset)
    responseValid |-> sent < granted)
    else begin
      $error("Response sent without an unspent credit");
      failures++;
    end

  quietInReset: assert property (@(posedge clock)
    reset |=> !commandCredit && !responseValid)
    else begin
      $error("Credit or response pulse while in reset");
      failures++;
    end

  creditNeedsCommand: assert property (@(posedge clock) disable iff (reset)
    commandCredit |-> returned < accepted)
    else begin
      $error("Command credit returned with no command held");
      failures++;
    end

endmodule
